//--- all.f
src/i2c_bus_pkg.sv
src/i2c_host_pkg.sv
src/i2c_hold_reg.sv
src/i2c_line_sampler.sv
src/i2c_bit_sequencer.sv
src/i2c_byte_sequencer.sv
src/i2c_master_top.sv
testbench/tb_i2c_slave_model.sv
testbench/tb_i2c_master.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = tb_i2c_master
FILELIST  = all.f
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_i2c_master.sv
// ----------------------------------------------------------------------
// testbench for the I2C byte engine with a slave model on the bus
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_i2c_master;

	localparam int PRESCALE_W   = 16;
	localparam int PRESCALE     = 4;
	localparam int BW           = i2c_host_pkg::BYTE_W;
	localparam int STALL_CYCLES = 400;
	localparam int TOTAL_BITS   = 90; // bit commands of all tests, with margin
	localparam int MAX_CYCLES   = TOTAL_BITS * 4 * (PRESCALE + 1) * 2 + STALL_CYCLES + 500;
	localparam int BUSY_WAIT    = 8 * (PRESCALE + 1); // sampler latency after a STOP, with margin

	logic                clk = 1'b0;
	logic                nReset;
	logic                cmd_valid;
	logic                cmd_ready;
	i2c_host_pkg::cmd_t  cmd;
	logic                resp_valid;
	logic                resp_ready;
	i2c_host_pkg::resp_t resp;
	logic                scl_oen, sda_oen, bus_busy;
	logic                scl, sda;
	logic                nack;
	logic [BW-1:0]       read_byte;
	logic                sda_pull;
	logic [BW-1:0]       slave_byte;
	logic                slave_mack;
	logic [7:0]          slave_cnt;

	integer        seed;
	int            cycles = 0;
	int            errors = 0;
	int            tests  = 0;
	int            failed = 0;
	int            test_err0 = 0;
	string         test_name = "reset";
	logic [BW-1:0] sent_q[$]; // written bytes whose responses are due

	// wired-AND bus, pull-ups implied
	assign scl = scl_oen;
	assign sda = sda_oen & ~sda_pull;

	always
		#4 clk = ~clk;

	i2c_master_top #(.PRESCALE_W(PRESCALE_W)) i_dut (
		.clk          (clk),
		.nReset       (nReset),
		.prescale_i   (PRESCALE_W'(PRESCALE)),
		.cmd_valid_i  (cmd_valid),
		.cmd_ready_o  (cmd_ready),
		.cmd_i        (cmd),
		.resp_valid_o (resp_valid),
		.resp_ready_i (resp_ready),
		.resp_o       (resp),
		.scl_i        (scl),
		.sda_i        (sda),
		.scl_oen_o    (scl_oen),
		.sda_oen_o    (sda_oen),
		.bus_busy_o   (bus_busy)
	);

	tb_i2c_slave_model u_slave (
		.clk          (clk),
		.nReset       (nReset),
		.scl_i        (scl),
		.sda_i        (sda),
		.nack_i       (nack),
		.read_byte_i  (read_byte),
		.sda_pull_o   (sda_pull),
		.last_byte_o  (slave_byte),
		.master_ack_o (slave_mack),
		.byte_cnt_o   (slave_cnt)
	);

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, test %s did not complete", cycles, test_name);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [BW-1:0] next_byte();
		return BW'($random(seed));
	endfunction

	function automatic i2c_host_pkg::cmd_t make_cmd(input logic start, input logic stop,
		input logic read, input logic write, input logic ack_in, input logic [BW-1:0] data);
		i2c_host_pkg::cmd_t c;
		c.start  = start;
		c.stop   = stop;
		c.read   = read;
		c.write  = write;
		c.ack_in = ack_in;
		c.data   = data;
		return c;
	endfunction

	task open_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task close_test();
		tests = tests + 1;
		if (errors > test_err0)
		begin
			failed = failed + 1;
			$display("test %s: %0d error(s)", test_name, errors - test_err0);
		end
		else
			$display("test %s: passed", test_name);
	endtask

	task check_equal(input string what, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			$display("ERROR %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
			errors = errors + 1;
		end
	endtask

	task check_true(input logic ok, input string msg);
		assert (ok)
		else
		begin
			$display("test %s failed: %s", test_name, msg);
			errors = errors + 1;
		end
	endtask

	// called and returns just after a falling edge
	task send_cmd(input i2c_host_pkg::cmd_t c);
		logic taken;
		cmd       = c;
		cmd_valid = 1'b1;
		taken     = 1'b0;
		while (!taken)
		begin
			taken = cmd_ready; // transfer on the coming rising edge
			@(negedge clk);
		end
		cmd_valid = 1'b0;
	endtask

	task take_resp(output i2c_host_pkg::resp_t r);
		resp_ready = 1'b1;
		while (!resp_valid)
			@(negedge clk);
		r = resp;
		@(negedge clk);
		resp_ready = 1'b0;
	endtask

	// gives up after limit cycles so a stuck busy flag is caught by the caller
	task wait_bus_free(input int limit);
		int n;
		n = 0;
		while (bus_busy && n < limit)
		begin
			@(negedge clk);
			n = n + 1;
		end
	endtask

	initial
	begin
		i2c_host_pkg::resp_t r;
		i2c_host_pkg::resp_t held;
		logic [BW-1:0]       addr;
		logic [BW-1:0]       d1;
		logic [BW-1:0]       d2;
		logic                stable;
		int                  cnt0;

		seed       = 32'h3073_da09;
		nReset     = 1'b0;
		cmd_valid  = 1'b0;
		cmd        = '0;
		resp_ready = 1'b0;
		nack       = 1'b0;
		read_byte  = next_byte();
		repeat (4) @(posedge clk);
		@(negedge clk);
		nReset = 1'b1;
		@(negedge clk);

		open_test("reset_state");
		check_equal("cmd_ready_o", 1, int'(cmd_ready));
		check_equal("resp_valid_o", 0, int'(resp_valid));
		check_equal("bus_busy_o", 0, int'(bus_busy));
		check_equal("scl_oen_o", 1, int'(scl_oen));
		check_equal("sda_oen_o", 1, int'(sda_oen));
		close_test();

		open_test("write_with_start");
		addr = next_byte() & 8'hfe; // write direction
		send_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, addr));
		take_resp(r);
		check_equal("rx_ack", 0, int'(r.rx_ack));
		check_equal("byte stored by slave", int'(addr), int'(slave_byte));
		check_equal("bus_busy_o", 1, int'(bus_busy));
		close_test();

		// repeated start with read direction, then one byte and a nack
		open_test("read_nack_stop");
		send_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, addr | 8'h01));
		take_resp(r);
		check_equal("address rx_ack", 0, int'(r.rx_ack));
		send_cmd(make_cmd(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h00));
		take_resp(r);
		check_equal("rx_data", int'(read_byte), int'(r.rx_data));
		check_equal("master ack seen by slave", 1, int'(slave_mack));
		wait_bus_free(BUSY_WAIT);
		check_equal("bus_busy_o after stop", 0, int'(bus_busy));
		close_test();

		open_test("write_nack");
		nack = 1'b1;
		send_cmd(make_cmd(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, next_byte() & 8'hfe));
		take_resp(r);
		check_equal("rx_ack", 1, int'(r.rx_ack));
		wait_bus_free(BUSY_WAIT);
		nack = 1'b0;
		close_test();

		// response register full, one command running, one waiting
		open_test("back_pressure");
		cnt0 = int'(slave_cnt);
		addr = next_byte() & 8'hfe;
		d1   = next_byte();
		d2   = next_byte();
		sent_q.push_back(addr);
		sent_q.push_back(d1);
		sent_q.push_back(d2);
		send_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, addr));
		send_cmd(make_cmd(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, d1));
		send_cmd(make_cmd(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, d2));
		check_equal("cmd_ready_o with two commands queued", 0, int'(cmd_ready));
		while (!resp_valid)
			@(negedge clk);
		held   = resp;
		stable = 1'b1;
		repeat (STALL_CYCLES)
		begin
			@(negedge clk);
			if (!resp_valid || resp != held)
				stable = 1'b0;
		end
		check_true(stable, "resp_o changed or resp_valid_o fell while resp_ready_i was low");
		check_equal("cmd_ready_o while stalled", 0, int'(cmd_ready));
		while (sent_q.size() > 0)
		begin
			take_resp(r);
			check_equal("rx_data in order", int'(sent_q.pop_front()), int'(r.rx_data));
			check_equal("rx_ack", 0, int'(r.rx_ack));
		end
		wait_bus_free(BUSY_WAIT);
		check_equal("bytes stored by slave", cnt0 + 3, int'(slave_cnt));
		close_test();

		open_test("stop_only");
		addr = next_byte() & 8'hfe;
		send_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, addr));
		take_resp(r);
		check_equal("bus_busy_o before stop", 1, int'(bus_busy));
		send_cmd(make_cmd(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, next_byte()));
		take_resp(r);
		check_equal("rx_data", 0, int'(r.rx_data));
		wait_bus_free(BUSY_WAIT);
		check_equal("bus_busy_o after stop", 0, int'(bus_busy));
		close_test();

		$display("tests run: %0d, tests failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- testbench/tb_i2c_slave_model.sv
// ----------------------------------------------------------------------
// behavioural I2C slave for the testbench, sampled on the system clock
// acks or nacks each byte, logs written bytes, serves read_byte_i on reads
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_i2c_slave_model (
	input  logic       clk,
	input  logic       nReset,
	input  logic       scl_i,
	input  logic       sda_i,
	input  logic       nack_i,       // refuse every byte
	input  logic [7:0] read_byte_i,  // byte served on reads
	output logic       sda_pull_o,   // high pulls sda low
	output logic [7:0] last_byte_o,  // last byte received
	output logic       master_ack_o, // ack bit sent by the master after a read
	output logic [7:0] byte_cnt_o    // bytes received so far
);

	typedef enum logic [2:0]
	{
		P_IDLE,
		P_RX,
		P_ACK,
		P_TX,
		P_MACK
	} phase_t;

	phase_t     phase;
	logic       scl_q, sda_q; // previous line levels
	logic [7:0] rx_sh;
	logic [7:0] tx_sh;
	logic [3:0] cnt;
	logic       first;        // next byte is the address
	logic       rd;           // address asked for a read

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			phase        <= P_IDLE;
			scl_q        <= 1'b1;
			sda_q        <= 1'b1;
			rx_sh        <= '0;
			tx_sh        <= '0;
			cnt          <= '0;
			first        <= 1'b0;
			rd           <= 1'b0;
			sda_pull_o   <= 1'b0;
			last_byte_o  <= '0;
			master_ack_o <= 1'b0;
			byte_cnt_o   <= '0;
		end
		else
		begin
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (scl_i && scl_q && sda_q && !sda_i) // START, repeated too
			begin
				phase      <= P_RX;
				cnt        <= '0;
				first      <= 1'b1;
				sda_pull_o <= 1'b0;
			end
			else if (scl_i && scl_q && !sda_q && sda_i) // STOP
			begin
				phase      <= P_IDLE;
				sda_pull_o <= 1'b0;
			end
			else if (scl_i && !scl_q) // scl rise, sample
			begin
				if (phase == P_RX)
				begin
					rx_sh <= {rx_sh[6:0], sda_i};
					cnt   <= cnt + 4'd1;
				end
				else if (phase == P_MACK)
					master_ack_o <= sda_i;
			end
			else if (!scl_i && scl_q) // scl fall, change sda
				case (phase)
					P_RX:
						if (cnt == 4'd8)
						begin
							last_byte_o <= rx_sh;
							byte_cnt_o  <= byte_cnt_o + 8'd1;
							if (first)
								rd <= rx_sh[0]; // r/w bit of the address
							first      <= 1'b0;
							sda_pull_o <= !nack_i;
							phase      <= P_ACK;
						end
					P_ACK:
					begin
						cnt <= '0;
						if (nack_i)
						begin
							phase      <= P_IDLE;
							sda_pull_o <= 1'b0;
						end
						else if (rd)
						begin
							phase      <= P_TX;
							sda_pull_o <= !read_byte_i[7];
							tx_sh      <= {read_byte_i[6:0], 1'b0};
							cnt        <= 4'd1;
						end
						else
						begin
							phase      <= P_RX;
							sda_pull_o <= 1'b0;
						end
					end
					P_TX:
						if (cnt == 4'd8)
						begin
							phase      <= P_MACK;
							sda_pull_o <= 1'b0; // master owns the ack bit
						end
						else
						begin
							sda_pull_o <= !tx_sh[7];
							tx_sh      <= {tx_sh[6:0], 1'b0};
							cnt        <= cnt + 4'd1;
						end
					P_MACK:
						if (!master_ack_o)
						begin
							phase      <= P_TX;
							sda_pull_o <= !read_byte_i[7];
							tx_sh      <= {read_byte_i[6:0], 1'b0};
							cnt        <= 4'd1;
						end
						else
						begin
							phase      <= P_IDLE; // nack ends the read
							sda_pull_o <= 1'b0;
						end
					default:
						sda_pull_o <= 1'b0;
				endcase
		end

endmodule

//--- src/i2c_master_top.sv
// ----------------------------------------------------------------------
// I2C byte engine top: host command/response ports and open-drain pins
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module i2c_master_top #(
	parameter int PRESCALE_W = i2c_host_pkg::DEF_PRESCALE_W
) (
	input  logic                  clk,
	input  logic                  nReset,
	input  logic [PRESCALE_W-1:0] prescale_i,
	input  logic                  cmd_valid_i,
	output logic                  cmd_ready_o,
	input  i2c_host_pkg::cmd_t    cmd_i,
	output logic                  resp_valid_o,
	input  logic                  resp_ready_i,
	output i2c_host_pkg::resp_t   resp_o,
	input  logic                  scl_i,
	input  logic                  sda_i,
	output logic                  scl_oen_o,
	output logic                  sda_oen_o,
	output logic                  bus_busy_o
);

	logic                  exec_valid, exec_ready;
	i2c_host_pkg::cmd_t    exec_cmd;
	logic                  res_valid, res_ready;
	i2c_host_pkg::resp_t   res;
	i2c_bus_pkg::line_t    line;
	logic                  bit_req, bit_done, tx_bit, rx_bit;
	i2c_bus_pkg::bit_cmd_t bit_cmd;

	assign bus_busy_o = line.bus_busy;

	i2c_hold_reg #(.payload_t(i2c_host_pkg::cmd_t)) u_cmd_reg (
		.clk         (clk),
		.nReset      (nReset),
		.in_valid_i  (cmd_valid_i),
		.in_ready_o  (cmd_ready_o),
		.in_i        (cmd_i),
		.out_valid_o (exec_valid),
		.out_ready_i (exec_ready),
		.out_o       (exec_cmd)
	);

	i2c_line_sampler #(.PRESCALE_W(PRESCALE_W)) u_sampler (
		.clk        (clk),
		.nReset     (nReset),
		.prescale_i (prescale_i),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.line_o     (line)
	);

	i2c_byte_sequencer u_byte_seq (
		.clk          (clk),
		.nReset       (nReset),
		.cmd_valid_i  (exec_valid),
		.cmd_ready_o  (exec_ready),
		.cmd_i        (exec_cmd),
		.resp_valid_o (res_valid),
		.resp_ready_i (res_ready),
		.resp_o       (res),
		.bit_req_o    (bit_req),
		.bit_cmd_o    (bit_cmd),
		.tx_bit_o     (tx_bit),
		.bit_done_i   (bit_done),
		.rx_bit_i     (rx_bit)
	);

	i2c_bit_sequencer #(.PRESCALE_W(PRESCALE_W)) u_bit_seq (
		.clk        (clk),
		.nReset     (nReset),
		.prescale_i (prescale_i),
		.line_i     (line),
		.bit_req_i  (bit_req),
		.bit_cmd_i  (bit_cmd),
		.tx_bit_i   (tx_bit),
		.bit_done_o (bit_done),
		.rx_bit_o   (rx_bit),
		.scl_oen_o  (scl_oen_o),
		.sda_oen_o  (sda_oen_o)
	);

	i2c_hold_reg #(.payload_t(i2c_host_pkg::resp_t)) u_resp_reg (
		.clk         (clk),
		.nReset      (nReset),
		.in_valid_i  (res_valid),
		.in_ready_o  (res_ready),
		.in_i        (res),
		.out_valid_o (resp_valid_o),
		.out_ready_i (resp_ready_i),
		.out_o       (resp_o)
	);

endmodule

//--- src/i2c_byte_sequencer.sv
// ----------------------------------------------------------------------
// splits a host byte command into bit commands, builds the response
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module i2c_byte_sequencer (
	input  logic                   clk,
	input  logic                   nReset,
	input  logic                   cmd_valid_i,
	output logic                   cmd_ready_o,
	input  i2c_host_pkg::cmd_t     cmd_i,
	output logic                   resp_valid_o,
	input  logic                   resp_ready_i,
	output i2c_host_pkg::resp_t    resp_o,
	output logic                   bit_req_o,
	output i2c_bus_pkg::bit_cmd_t  bit_cmd_o,
	output logic                   tx_bit_o,
	input  logic                   bit_done_i,
	input  logic                   rx_bit_i
);

	localparam int BW    = i2c_host_pkg::BYTE_W;
	localparam int CNT_W = $clog2(BW);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_START,
		ST_WRITE,
		ST_READ,
		ST_ACK,
		ST_STOP,
		ST_RESPOND
	} state_t;

	state_t             state;
	i2c_host_pkg::cmd_t cmd_q;
	logic [BW-1:0]      sr;    // tx data out, rx data in
	logic [CNT_W-1:0]   dcnt;  // bits left
	logic               ack_q;
	logic               last_bit;
	logic               shift;

	assign last_bit = (dcnt == '0);
	assign shift    = bit_done_i && (state == ST_WRITE || state == ST_READ);

	assign cmd_ready_o  = (state == ST_IDLE);
	assign resp_valid_o = (state == ST_RESPOND);
	assign resp_o.rx_data = sr;
	assign resp_o.rx_ack  = ack_q;
	// master ack after a read, otherwise the data MSB
	assign tx_bit_o = (state == ST_ACK) ? cmd_q.ack_in : sr[BW-1];

	// datapath
	always_ff @(posedge clk)
		if (cmd_valid_i && cmd_ready_o)
		begin
			cmd_q <= cmd_i;
			sr    <= cmd_i.write ? cmd_i.data : '0;
			dcnt  <= CNT_W'(BW - 1);
			ack_q <= 1'b0;
		end
		else if (shift)
		begin
			sr   <= {sr[BW-2:0], rx_bit_i}; // msb first
			dcnt <= dcnt - 1'b1;
		end
		else if (bit_done_i && state == ST_ACK)
			ack_q <= rx_bit_i;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			state     <= ST_IDLE;
			bit_req_o <= 1'b0;
			bit_cmd_o <= i2c_bus_pkg::BIT_START;
		end
		else
			case (state)
				ST_IDLE:
					if (cmd_valid_i)
					begin
						bit_req_o <= 1'b1;
						if (cmd_i.start)
						begin
							state     <= ST_START;
							bit_cmd_o <= i2c_bus_pkg::BIT_START;
						end
						else if (cmd_i.read)
						begin
							state     <= ST_READ;
							bit_cmd_o <= i2c_bus_pkg::BIT_READ;
						end
						else if (cmd_i.write)
						begin
							state     <= ST_WRITE;
							bit_cmd_o <= i2c_bus_pkg::BIT_WRITE;
						end
						else // stop only
						begin
							state     <= ST_STOP;
							bit_cmd_o <= i2c_bus_pkg::BIT_STOP;
						end
					end
				ST_START:
					if (bit_done_i)
					begin
						if (cmd_q.read)
						begin
							state     <= ST_READ;
							bit_cmd_o <= i2c_bus_pkg::BIT_READ;
						end
						else if (cmd_q.write)
						begin
							state     <= ST_WRITE;
							bit_cmd_o <= i2c_bus_pkg::BIT_WRITE;
						end
						else if (cmd_q.stop)
						begin
							state     <= ST_STOP;
							bit_cmd_o <= i2c_bus_pkg::BIT_STOP;
						end
						else
						begin
							state     <= ST_RESPOND;
							bit_req_o <= 1'b0;
						end
					end
				ST_WRITE:
					if (bit_done_i && last_bit)
					begin
						state     <= ST_ACK;
						bit_cmd_o <= i2c_bus_pkg::BIT_READ; // slave ack
					end
				ST_READ:
					if (bit_done_i && last_bit)
					begin
						state     <= ST_ACK;
						bit_cmd_o <= i2c_bus_pkg::BIT_WRITE; // master ack
					end
				ST_ACK:
					if (bit_done_i)
					begin
						if (cmd_q.stop)
						begin
							state     <= ST_STOP;
							bit_cmd_o <= i2c_bus_pkg::BIT_STOP;
						end
						else
						begin
							state     <= ST_RESPOND;
							bit_req_o <= 1'b0;
						end
					end
				ST_STOP:
					if (bit_done_i)
					begin
						state     <= ST_RESPOND;
						bit_req_o <= 1'b0;
					end
				ST_RESPOND:
					if (resp_ready_i)
						state <= ST_IDLE; // waits here under back-pressure
				default: state <= ST_IDLE;
			endcase

endmodule

//--- src/i2c_bit_sequencer.sv
// ----------------------------------------------------------------------
// runs one START, STOP, READ or WRITE bit on the bus in clk_en phases
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module i2c_bit_sequencer #(
	parameter int PRESCALE_W = i2c_host_pkg::DEF_PRESCALE_W
) (
	input  logic                   clk,
	input  logic                   nReset,
	input  logic [PRESCALE_W-1:0]  prescale_i,
	input  i2c_bus_pkg::line_t     line_i,
	input  logic                   bit_req_i,
	input  i2c_bus_pkg::bit_cmd_t  bit_cmd_i,
	input  logic                   tx_bit_i,
	output logic                   bit_done_o,
	output logic                   rx_bit_o,
	output logic                   scl_oen_o,
	output logic                   sda_oen_o
);

	// one-hot phases, idle is all zero
	typedef enum logic [16:0]
	{
		IDLE    = 17'h00000,
		START_A = 17'h00001,
		START_B = 17'h00002,
		START_C = 17'h00004,
		START_D = 17'h00008,
		START_E = 17'h00010,
		STOP_A  = 17'h00020,
		STOP_B  = 17'h00040,
		STOP_C  = 17'h00080,
		STOP_D  = 17'h00100,
		RD_A    = 17'h00200,
		RD_B    = 17'h00400,
		RD_C    = 17'h00800,
		RD_D    = 17'h01000,
		WR_A    = 17'h02000,
		WR_B    = 17'h04000,
		WR_C    = 17'h08000,
		WR_D    = 17'h10000
	} phase_t;

	phase_t                c_state;
	logic [PRESCALE_W-1:0] cnt;
	logic                  clk_en;

	// one tick every prescale_i+1 cycles
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			cnt    <= '0;
			clk_en <= 1'b1;
		end
		else if (cnt == '0)
		begin
			cnt    <= prescale_i;
			clk_en <= 1'b1;
		end
		else
		begin
			cnt    <= cnt - 1'b1;
			clk_en <= 1'b0;
		end

	// sample sda on each scl rise
	always_ff @(posedge clk)
		if (line_i.scl_rise)
			rx_bit_o <= line_i.sda;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			c_state    <= IDLE;
			bit_done_o <= 1'b0;
			scl_oen_o  <= 1'b1;
			sda_oen_o  <= 1'b1;
		end
		else
		begin
			bit_done_o <= 1'b0; // single cycle pulse
			if (clk_en)
				case (c_state)
					IDLE:
						if (bit_req_i)
							case (bit_cmd_i)
								i2c_bus_pkg::BIT_START: c_state <= START_A;
								i2c_bus_pkg::BIT_STOP:  c_state <= STOP_A;
								i2c_bus_pkg::BIT_WRITE: c_state <= WR_A;
								default:                c_state <= RD_A;
							endcase
					START_A:
					begin
						c_state   <= START_B;
						sda_oen_o <= 1'b1; // release sda
					end
					START_B:
					begin
						c_state   <= START_C;
						scl_oen_o <= 1'b1;
					end
					START_C:
					begin
						c_state   <= START_D;
						sda_oen_o <= 1'b0; // sda falls, scl high
					end
					START_D: c_state <= START_E;
					START_E:
					begin
						c_state    <= IDLE;
						bit_done_o <= 1'b1;
						scl_oen_o  <= 1'b0;
					end
					STOP_A:
					begin
						c_state   <= STOP_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b0;
					end
					STOP_B:
					begin
						c_state   <= STOP_C;
						scl_oen_o <= 1'b1;
					end
					STOP_C: c_state <= STOP_D;
					STOP_D:
					begin
						c_state    <= IDLE;
						bit_done_o <= 1'b1;
						sda_oen_o  <= 1'b1; // sda rises, scl high
					end
					RD_A:
					begin
						c_state   <= RD_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b1; // slave drives sda
					end
					RD_B:
					begin
						c_state   <= RD_C;
						scl_oen_o <= 1'b1;
					end
					RD_C: c_state <= RD_D;
					RD_D:
					begin
						c_state    <= IDLE;
						bit_done_o <= 1'b1;
						scl_oen_o  <= 1'b0;
					end
					WR_A:
					begin
						c_state   <= WR_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= tx_bit_i; // data changes while scl low
					end
					WR_B:
					begin
						c_state   <= WR_C;
						scl_oen_o <= 1'b1;
					end
					WR_C: c_state <= WR_D;
					WR_D:
					begin
						c_state    <= IDLE;
						bit_done_o <= 1'b1;
						scl_oen_o  <= 1'b0;
					end
					default: c_state <= IDLE;
				endcase
		end

endmodule

//--- src/i2c_line_sampler.sv
// ----------------------------------------------------------------------
// samples SCL/SDA, filters glitches and tracks START, STOP and busy
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module i2c_line_sampler #(
	parameter int PRESCALE_W = i2c_host_pkg::DEF_PRESCALE_W
) (
	input  logic                   clk,
	input  logic                   nReset,
	input  logic [PRESCALE_W-1:0]  prescale_i,
	input  logic                   scl_i,
	input  logic                   sda_i,
	output i2c_bus_pkg::line_t     line_o
);

	localparam int FCNT_W = PRESCALE_W - i2c_bus_pkg::FILTER_SHIFT;

	logic [1:0]        cscl, csda; // input capture
	logic [2:0]        fscl, fsda; // filter taps
	logic [FCNT_W-1:0] filter_cnt;
	logic              sscl, ssda; // filtered
	logic              dscl, dsda; // delayed filtered
	logic              sta_cond, sto_cond;
	logic              busy;

	function automatic logic maj3(input logic [2:0] v);
		return (v[2] & v[1]) | (v[1] & v[0]) | (v[2] & v[0]);
	endfunction

	// two flops against metastability
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			cscl <= 2'b11;
			csda <= 2'b11;
		end
		else
		begin
			cscl <= {cscl[0], scl_i};
			csda <= {csda[0], sda_i};
		end

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
			filter_cnt <= '0;
		else if (filter_cnt == '0)
			filter_cnt <= prescale_i[PRESCALE_W-1:i2c_bus_pkg::FILTER_SHIFT];
		else
			filter_cnt <= filter_cnt - 1'b1;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			fscl <= 3'b111;
			fsda <= 3'b111;
		end
		else if (filter_cnt == '0) // filter tick
		begin
			fscl <= {fscl[1:0], cscl[1]};
			fsda <= {fsda[1:0], csda[1]};
		end

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			sscl <= 1'b1;
			ssda <= 1'b1;
			dscl <= 1'b1;
			dsda <= 1'b1;
		end
		else
		begin
			sscl <= maj3(fscl);
			ssda <= maj3(fsda);
			dscl <= sscl;
			dsda <= ssda;
		end

	// sda falling with scl high is START, rising is STOP
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			sta_cond <= 1'b0;
			sto_cond <= 1'b0;
			busy     <= 1'b0;
		end
		else
		begin
			sta_cond <= ~ssda & dsda & sscl;
			sto_cond <= ssda & ~dsda & sscl;
			busy     <= (sta_cond | busy) & ~sto_cond;
		end

	assign line_o.scl      = sscl;
	assign line_o.sda      = ssda;
	assign line_o.scl_rise = sscl & ~dscl;
	assign line_o.bus_busy = busy;

endmodule

//--- src/i2c_hold_reg.sv
// ----------------------------------------------------------------------
// single-entry valid/ready register, used for commands and responses
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module i2c_hold_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     nReset,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  payload_t in_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output payload_t out_o
);

	logic     full;
	payload_t data;

	// take a new entry when empty or when the old one leaves now
	assign in_ready_o  = ~full | out_ready_i;
	assign out_valid_o = full;
	assign out_o       = data;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
			full <= 1'b0;
		else if (in_ready_o)
			full <= in_valid_i;

	always_ff @(posedge clk)
		if (in_valid_i && in_ready_o)
			data <= in_i;

endmodule

//--- src/i2c_host_pkg.sv
// ----------------------------------------------------------------------
// host-side command and response formats of the byte engine
// ----------------------------------------------------------------------
package i2c_host_pkg;

	localparam int BYTE_W = 8;          // data width
	localparam int DEF_PRESCALE_W = 16; // default prescale port width

	// one byte command from the host
	typedef struct packed
	{
		logic              start;  // START before the byte
		logic              stop;   // STOP after the byte
		logic              read;   // read one byte
		logic              write;  // write one byte
		logic              ack_in; // ack to send after a read
		logic [BYTE_W-1:0] data;   // byte to write
	} cmd_t;

	// result of one byte command
	typedef struct packed
	{
		logic [BYTE_W-1:0] rx_data; // received byte
		logic              rx_ack;  // ack bit seen on the bus
	} resp_t;

endpackage

//--- src/i2c_bus_pkg.sv
// ----------------------------------------------------------------------
// bus-side definitions shared by the line sampler and the bit sequencer
// ----------------------------------------------------------------------
package i2c_bus_pkg;

	// bit-level commands from the byte sequencer
	typedef enum logic [1:0]
	{
		BIT_START = 2'b00,
		BIT_STOP  = 2'b01,
		BIT_WRITE = 2'b10,
		BIT_READ  = 2'b11
	} bit_cmd_t;

	// filtered view of the bus
	typedef struct packed
	{
		logic scl;      // filtered scl
		logic sda;      // filtered sda
		logic scl_rise; // one-cycle strobe on scl rising
		logic bus_busy; // between START and STOP
	} line_t;

	// filter tick = prescale >> 2, i.e. 16x the bit rate
	localparam int FILTER_SHIFT = 2;

endpackage
